// ==== src/huff_pkg.sv ====
package huff_pkg;

	// width of one decoded magnitude
	localparam int abs_w = 4;

	// magnitude that is followed by escape bits
	localparam logic [abs_w-1:0] esc_abs = 4'd15;

	// longest code in the table
	localparam int code_bits_max = 9;

	// values per codeword, x then y
	localparam int num_lanes = 2;

	typedef struct packed {
		logic [abs_w-1:0] x_abs;
		logic [abs_w-1:0] y_abs;
	} mag_pair_s;

	// index 0 lands on the upper nibble, so lane 0 is x
	typedef logic [0:num_lanes-1][abs_w-1:0] mag_lane_t;

	// one byte, read as a named pair or as per-lane nibbles
	typedef union packed {
		mag_pair_s pair;
		mag_lane_t lane;
	} mag_pair_u;

endpackage

// ==== src/code_bus.sv ====
`timescale 1ns/1ps

interface code_bus
	import huff_pkg::*;
(
	input logic clk,
	input logic rst
);

	logic      found;
	mag_pair_u mags;
	logic      bit_data;
	logic      bit_valid;
	logic      restart;

	modport matcher (
		input  restart,
		output found,
		output mags,
		output bit_data,
		output bit_valid
	);

	modport lane (
		input bit_data,
		input bit_valid,
		input restart
	);

	modport assembler (
		input  clk,
		input  rst,
		input  found,
		input  bit_valid,
		output restart
	);

endinterface

// ==== src/codeword_matcher.sv ====
`timescale 1ns/1ps

module codeword_matcher
	import huff_pkg::*;
(
	input logic      clk,
	input logic      rst,
	input logic      bit_valid,
	input logic      bit_data,
	code_bus.matcher bus
);

	localparam int cnt_w = $clog2(code_bits_max + 1);

	logic [code_bits_max-1:0] shift_q;
	logic [cnt_w-1:0]         cnt;
	// match flag on top of the magnitude pair
	logic [2*abs_w:0]         cw;
	logic                     hit;

	function automatic logic [2*abs_w:0] pair_hit(input logic [abs_w-1:0] x,
			input logic [abs_w-1:0] y);
		mag_pair_u m;
		m.pair.x_abs = x;
		m.pair.y_abs = y;
		return {1'b1, m};
	endfunction

	assign hit = cw[2*abs_w];

	// newest bit at bit 0, so a code of length n sits in shift_q[n-1:0]
	always_ff @(posedge clk) begin
		if (bit_valid && (bus.restart || !hit)) begin
			shift_q <= {shift_q[code_bits_max-2:0], bit_data};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (bus.restart) begin
			// a bit in the restart cycle is bit 1 of the next code
			cnt <= bit_valid ? cnt_w'(1) : '0;
		end else if (bit_valid && !hit) begin
			cnt <= cnt + 1'b1;
		end
	end

	// codebook, lengths 1 to 9
	always_comb begin
		cw = '0;
		case (cnt)
			cnt_w'(1): begin
				if (shift_q[0])
					cw = pair_hit(4'd0, 4'd0);
			end
			cnt_w'(3): begin
				if (shift_q[2:0] == 3'b011)
					cw = pair_hit(4'd1, 4'd0);
			end
			cnt_w'(4): begin
				case (shift_q[3:0])
					4'b0101: cw = pair_hit(4'd0, 4'd1);
					4'b0100: cw = pair_hit(4'd1, 4'd1);
					default: cw = '0;
				endcase
			end
			cnt_w'(6): begin
				case (shift_q[5:0])
					6'b001110: cw = pair_hit(4'd0, 4'd2);
					6'b001100: cw = pair_hit(4'd1, 4'd2);
					6'b001111: cw = pair_hit(4'd2, 4'd0);
					6'b001101: cw = pair_hit(4'd2, 4'd1);
					default:   cw = '0;
				endcase
			end
			cnt_w'(7): begin
				case (shift_q[6:0])
					7'b0010100: cw = pair_hit(4'd1, 4'd3);
					7'b0010111: cw = pair_hit(4'd2, 4'd2);
					7'b0010101: cw = pair_hit(4'd3, 4'd1);
					default:    cw = '0;
				endcase
			end
			cnt_w'(8): begin
				case (shift_q[7:0])
					8'b00101100: cw = pair_hit(4'd0, 4'd3);
					8'b00100011: cw = pair_hit(4'd1, 4'd4);
					8'b00001001: cw = pair_hit(4'd1, 4'd15);
					8'b00100110: cw = pair_hit(4'd2, 4'd3);
					8'b00101101: cw = pair_hit(4'd3, 4'd0);
					8'b00100111: cw = pair_hit(4'd3, 4'd2);
					8'b00100100: cw = pair_hit(4'd4, 4'd1);
					8'b00011110: cw = pair_hit(4'd5, 4'd1);
					8'b00001010: cw = pair_hit(4'd15, 4'd1);
					8'b00000111: cw = pair_hit(4'd15, 4'd2);
					8'b00000011: cw = pair_hit(4'd15, 4'd15);
					default:     cw = '0;
				endcase
			end
			cnt_w'(9): begin
				case (shift_q[8:0])
					9'b001001010: cw = pair_hit(4'd0, 4'd4);
					9'b000111111: cw = pair_hit(4'd0, 4'd5);
					9'b000010001: cw = pair_hit(4'd0, 4'd15);
					9'b000111110: cw = pair_hit(4'd1, 4'd5);
					9'b000110101: cw = pair_hit(4'd1, 4'd6);
					9'b000101111: cw = pair_hit(4'd1, 4'd7);
					9'b001000011: cw = pair_hit(4'd2, 4'd4);
					9'b000111010: cw = pair_hit(4'd2, 4'd5);
					9'b000010000: cw = pair_hit(4'd2, 4'd15);
					9'b001000101: cw = pair_hit(4'd3, 4'd3);
					9'b001000000: cw = pair_hit(4'd3, 4'd4);
					9'b001001011: cw = pair_hit(4'd4, 4'd0);
					9'b001000100: cw = pair_hit(4'd4, 4'd2);
					9'b001000001: cw = pair_hit(4'd4, 4'd3);
					9'b000001001: cw = pair_hit(4'd4, 4'd15);
					9'b001000010: cw = pair_hit(4'd5, 4'd0);
					9'b000111011: cw = pair_hit(4'd5, 4'd2);
					9'b000111000: cw = pair_hit(4'd5, 4'd3);
					9'b000110110: cw = pair_hit(4'd6, 4'd1);
					9'b000110100: cw = pair_hit(4'd6, 4'd2);
					9'b000110000: cw = pair_hit(4'd7, 4'd1);
					9'b000001100: cw = pair_hit(4'd15, 4'd0);
					9'b000001011: cw = pair_hit(4'd15, 4'd3);
					9'b000001010: cw = pair_hit(4'd15, 4'd4);
					default:      cw = '0;
				endcase
			end
			default: cw = '0;
		endcase
	end

	assign bus.found     = hit;
	assign bus.mags      = cw[2*abs_w-1:0];
	assign bus.bit_data  = bit_data;
	assign bus.bit_valid = bit_valid;

	// codes past 9 bits are not in the table
	a_code_len: assert property (@(posedge clk) disable iff (rst)
		!bus.found |-> cnt <= cnt_w'(code_bits_max));

endmodule

// ==== src/escape_sign_lane.sv ====
`timescale 1ns/1ps

module escape_sign_lane
	import huff_pkg::*;
#(
	parameter int LIN_BITS = 10,
	parameter int VAL_W    = 16
) (
	input  logic                    clk,
	input  logic                    rst,
	code_bus.lane                   bus,
	input  logic [abs_w-1:0]        lane_idx_mag,
	input  logic                    prior_done,
	output logic                    done,
	output logic signed [VAL_W-1:0] value
);

	localparam int cnt_w = $clog2(LIN_BITS + 1);

	logic [cnt_w-1:0]        esc_cnt;
	logic [LIN_BITS-1:0]     esc_val;
	logic                    sign_taken;
	logic                    sign_q;
	logic                    need_esc;
	logic                    need_sign;
	logic                    take;
	logic signed [VAL_W-1:0] mag_sum;

	assign need_esc  = (lane_idx_mag == esc_abs) && (esc_cnt != cnt_w'(LIN_BITS));
	assign need_sign = (lane_idx_mag != '0) && !sign_taken;

	// escape field first, sign after it
	assign done = prior_done && !need_esc && !need_sign;
	assign take = bus.bit_valid && prior_done && (need_esc || need_sign);

	always_ff @(posedge clk) begin
		if (rst || bus.restart) begin
			esc_cnt    <= '0;
			esc_val    <= '0;
			sign_taken <= 1'b0;
			sign_q     <= 1'b0;
		end else if (take) begin
			if (need_esc) begin
				// msb first
				esc_val <= {esc_val[LIN_BITS-2:0], bus.bit_data};
				esc_cnt <= esc_cnt + 1'b1;
			end else begin
				sign_q     <= bus.bit_data;
				sign_taken <= 1'b1;
			end
		end
	end

	assign mag_sum = VAL_W'(lane_idx_mag) + VAL_W'(esc_val);
	assign value   = sign_q ? -mag_sum : mag_sum;

	// escape bits only ever follow the escape magnitude, at most LIN_BITS of them
	a_esc_cnt: assert property (@(posedge clk) disable iff (rst)
		esc_cnt != '0 |-> lane_idx_mag == esc_abs && esc_cnt <= cnt_w'(LIN_BITS));

endmodule

// ==== src/pair_assembler.sv ====
`timescale 1ns/1ps

module pair_assembler
	import huff_pkg::*;
#(
	parameter int VAL_W = 16
) (
	code_bus.assembler              bus,
	input  logic                    last_done,
	input  logic signed [VAL_W-1:0] lane_values [num_lanes],
	output logic                    pair_valid,
	output logic signed [VAL_W-1:0] x_val,
	output logic signed [VAL_W-1:0] y_val
);

	// completion of the last lane closes the pair and restarts everything
	assign pair_valid  = last_done;
	assign bus.restart = last_done;

	assign x_val = lane_values[0];
	assign y_val = lane_values[1];

	// back to back pairs only when a new bit came in the restart cycle
	a_pair_gap: assert property (@(posedge bus.clk) disable iff (bus.rst)
		pair_valid |=> !pair_valid || $past(bus.bit_valid));

	// a matched code holds until its pair closes
	a_found_hold: assert property (@(posedge bus.clk) disable iff (bus.rst)
		bus.found && !bus.restart |=> bus.found);

endmodule

// ==== src/huff_pair_decoder.sv ====
`timescale 1ns/1ps

module huff_pair_decoder
	import huff_pkg::*;
#(
	parameter int LIN_BITS = 10,
	parameter int VAL_W    = 16
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    bit_valid,
	input  logic                    bit_data,
	output logic                    pair_valid,
	output logic signed [VAL_W-1:0] x_val,
	output logic signed [VAL_W-1:0] y_val
);

	logic [num_lanes-1:0]    lane_done;
	logic [num_lanes-1:0]    lane_prior;
	logic signed [VAL_W-1:0] lane_value [num_lanes];

	code_bus bus (
		.clk (clk),
		.rst (rst)
	);

	codeword_matcher u_matcher (
		.clk       (clk),
		.rst       (rst),
		.bit_valid (bit_valid),
		.bit_data  (bit_data),
		.bus       (bus.matcher)
	);

	// lane 0 waits for the code, lane 1 for lane 0
	assign lane_prior = {lane_done[num_lanes-2:0], bus.found};

	for (genvar i = 0; i < num_lanes; i++) begin : g_lane
		escape_sign_lane #(
			.LIN_BITS (LIN_BITS),
			.VAL_W    (VAL_W)
		) u_lane (
			.clk          (clk),
			.rst          (rst),
			.bus          (bus.lane),
			.lane_idx_mag (bus.mags.lane[i]),
			.prior_done   (lane_prior[i]),
			.done         (lane_done[i]),
			.value        (lane_value[i])
		);
	end

	pair_assembler #(
		.VAL_W (VAL_W)
	) u_assembler (
		.bus         (bus.assembler),
		.last_done   (lane_done[num_lanes-1]),
		.lane_values (lane_value),
		.pair_valid  (pair_valid),
		.x_val       (x_val),
		.y_val       (y_val)
	);

endmodule

// ==== bench/pair_checker.sv ====
`timescale 1ns/1ps

module pair_checker #(
	parameter int VAL_W = 16
) (
	input logic                    clk,
	input logic                    rst,
	input logic                    pair_valid,
	input logic signed [VAL_W-1:0] x_val,
	input logic signed [VAL_W-1:0] y_val
);

	string name_q[$];
	int    exp_x_q[$];
	int    exp_y_q[$];
	int    pass_count = 0;
	int    fail_count = 0;

	task automatic push_expect(input string name, input int exp_x, input int exp_y);
		name_q.push_back(name);
		exp_x_q.push_back(exp_x);
		exp_y_q.push_back(exp_y);
	endtask

	function automatic int pending();
		return name_q.size();
	endfunction

	// outputs hold their values through the whole pair_valid cycle
	always @(posedge clk) begin
		string name;
		int    exp_x;
		int    exp_y;
		int    act_x;
		int    act_y;
		if (!rst && pair_valid) begin
			act_x = int'(x_val);
			act_y = int'(y_val);
			if (name_q.size() == 0) begin
				$display("ERROR: pair_valid with no test waiting for it, x=%0d y=%0d",
					act_x, act_y);
				fail_count++;
			end else begin
				name  = name_q.pop_front();
				exp_x = exp_x_q.pop_front();
				exp_y = exp_y_q.pop_front();
				if (act_x != exp_x || act_y != exp_y) begin
					$display("FAILED %s: expected x=%0d y=%0d, actual x=%0d y=%0d",
						name, exp_x, exp_y, act_x, act_y);
					fail_count++;
				end else begin
					$display("ok     %s: x=%0d y=%0d", name, act_x, act_y);
					pass_count++;
				end
			end
		end
	end

endmodule

// ==== bench/tb_huff_pair_decoder.sv ====
`timescale 1ns/1ps

module tb_huff_pair_decoder;

	localparam int lin_bits     = 10;
	localparam int val_w        = 16;
	localparam int esc_max      = (1 << lin_bits) - 1;
	localparam int pair_timeout = 32;
	localparam int drain_limit  = 8;

	typedef struct {
		string      name;
		logic [8:0] code;
		int         code_len;
		int         x_abs;
		int         y_abs;
		int         x_esc;
		int         y_esc;
		logic       x_sign;
		logic       y_sign;
		int         exp_x;
		int         exp_y;
	} row_t;

	logic                    clk;
	logic                    rst;
	logic                    bit_valid;
	logic                    bit_data;
	logic                    pair_valid;
	logic signed [val_w-1:0] x_val;
	logic signed [val_w-1:0] y_val;

	row_t        rows[$];
	logic [31:0] lfsr;
	logic        timeout_hit;
	logic        drain_err;

	huff_pair_decoder #(
		.LIN_BITS (lin_bits),
		.VAL_W    (val_w)
	) UUT (
		.clk        (clk),
		.rst        (rst),
		.bit_valid  (bit_valid),
		.bit_data   (bit_data),
		.pair_valid (pair_valid),
		.x_val      (x_val),
		.y_val      (y_val)
	);

	pair_checker #(
		.VAL_W (val_w)
	) u_checker (
		.clk        (clk),
		.rst        (rst),
		.pair_valid (pair_valid),
		.x_val      (x_val),
		.y_val      (y_val)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_rand(input int nbits, output int val);
		int k;
		val = 0;
		for (k = 0; k < nbits; k++) begin
			lfsr = lfsr_next(lfsr);
			val  = (val << 1) | int'(lfsr[0]);
		end
	endtask

	function automatic int signed_value(input int mag, input int esc, input logic sign);
		int v;
		v = mag + esc;
		return sign ? -v : v;
	endfunction

	task automatic add_row(input string name, input logic [8:0] code, input int code_len,
			input int x_abs, input int y_abs, input int x_esc, input int y_esc,
			input logic x_sign, input logic y_sign);
		row_t r;
		r.name     = name;
		r.code     = code;
		r.code_len = code_len;
		r.x_abs    = x_abs;
		r.y_abs    = y_abs;
		r.x_esc    = x_esc;
		r.y_esc    = y_esc;
		r.x_sign   = x_sign;
		r.y_sign   = y_sign;
		r.exp_x    = signed_value(x_abs, x_esc, x_sign);
		r.exp_y    = signed_value(y_abs, y_esc, y_sign);
		rows.push_back(r);
	endtask

	task automatic build_table();
		add_row("zero_pair",        9'b1,         1, 0,  0,  0,       0,       0, 0);
		add_row("one_zero_neg",     9'b011,       3, 1,  0,  0,       0,       1, 0);
		add_row("zero_one_pos",     9'b0101,      4, 0,  1,  0,       0,       0, 0);
		add_row("one_one_mixed",    9'b0100,      4, 1,  1,  0,       0,       0, 1);
		add_row("two_zero_neg",     9'b001111,    6, 2,  0,  0,       0,       1, 0);
		add_row("one_two_mixed",    9'b001100,    6, 1,  2,  0,       0,       1, 0);
		add_row("two_two_neg",      9'b0010111,   7, 2,  2,  0,       0,       1, 1);
		add_row("three_two_pos",    9'b00100111,  8, 3,  2,  0,       0,       0, 0);
		add_row("seven_one_mixed",  9'b000110000, 9, 7,  1,  0,       0,       0, 1);
		add_row("five_three_neg",   9'b000111000, 9, 5,  3,  0,       0,       1, 1);
		add_row("x_esc_pos",        9'b00001010,  8, 15, 1,  37,      0,       0, 1);
		add_row("x_esc_neg",        9'b000001100, 9, 15, 0,  512,     0,       1, 0);
		add_row("x_esc_small",      9'b000001011, 9, 15, 3,  1,       0,       1, 0);
		add_row("y_esc_neg",        9'b000010001, 9, 0,  15, 0,       681,     0, 1);
		add_row("y_esc_pos",        9'b00001001,  8, 1,  15, 0,       5,       1, 0);
		add_row("y_esc_four",       9'b000001001, 9, 4,  15, 0,       300,     0, 1);
		add_row("both_esc_zero",    9'b00000011,  8, 15, 15, 0,       0,       0, 0);
		add_row("both_esc_max_neg", 9'b00000011,  8, 15, 15, esc_max, esc_max, 1, 1);
		add_row("both_esc_max_mix", 9'b00000011,  8, 15, 15, esc_max, esc_max, 0, 1);
		add_row("zero_pair_b2b_a",  9'b1,         1, 0,  0,  0,       0,       0, 0);
		add_row("zero_pair_b2b_b",  9'b1,         1, 0,  0,  0,       0,       0, 0);
		add_row("one_zero_after",   9'b011,       3, 1,  0,  0,       0,       0, 0);
	endtask

	task automatic drive_bit(input logic b);
		bit_valid = 1'b1;
		bit_data  = b;
		@(negedge clk);
	endtask

	task automatic drive_idle(input int cycles);
		int k;
		for (k = 0; k < cycles; k++) begin
			bit_valid = 1'b0;
			@(negedge clk);
		end
	endtask

	// code, x escape, x sign, y escape, y sign
	task automatic send_row(input row_t r);
		logic bits[$];
		int   k;
		int   gap;
		for (k = r.code_len - 1; k >= 0; k--)
			bits.push_back(r.code[k]);
		if (r.x_abs == 15)
			for (k = lin_bits - 1; k >= 0; k--)
				bits.push_back(r.x_esc[k]);
		if (r.x_abs != 0)
			bits.push_back(r.x_sign);
		if (r.y_abs == 15)
			for (k = lin_bits - 1; k >= 0; k--)
				bits.push_back(r.y_esc[k]);
		if (r.y_abs != 0)
			bits.push_back(r.y_sign);
		// first bit goes straight into the previous pair_valid cycle
		for (k = 0; k < bits.size(); k++) begin
			if (k > 0) begin
				take_rand(2, gap);
				if (gap == 3)
					drive_idle(2);
				else if (gap == 2)
					drive_idle(1);
			end
			drive_bit(bits[k]);
		end
	endtask

	task automatic wait_pair(output logic seen);
		int n;
		n = 0;
		while (!pair_valid && n < pair_timeout) begin
			bit_valid = 1'b0;
			@(negedge clk);
			n++;
		end
		seen = pair_valid;
	endtask

	task automatic drain_checker();
		int n;
		n = 0;
		while (u_checker.pending() != 0 && n < drain_limit) begin
			@(negedge clk);
			n++;
		end
		if (u_checker.pending() != 0) begin
			$display("ERROR: checker still holds %0d expected pairs at the end",
				u_checker.pending());
			drain_err = 1'b1;
		end
	endtask

	task automatic finish_run();
		int fails;
		fails = u_checker.fail_count + int'(timeout_hit) + int'(drain_err);
		$display("summary: %0d tests, %0d passed, %0d failed",
			rows.size(), u_checker.pass_count, fails);
		if (fails == 0 && u_checker.pass_count == rows.size()) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	initial begin
		int   i;
		logic seen;
		rst         = 1'b1;
		bit_valid   = 1'b0;
		bit_data    = 1'b0;
		lfsr        = 32'h8054;
		timeout_hit = 1'b0;
		drain_err   = 1'b0;
		build_table();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (i = 0; i < rows.size(); i++) begin
			u_checker.push_expect(rows[i].name, rows[i].exp_x, rows[i].exp_y);
			send_row(rows[i]);
			wait_pair(seen);
			if (!seen) begin
				$display("ERROR: %s: no pair_valid within timeout", rows[i].name);
				timeout_hit = 1'b1;
				break;
			end
		end
		bit_valid = 1'b0;
		if (!timeout_hit)
			drain_checker();
		finish_run();
	end

endmodule

// ==== compile.f ====
src/huff_pkg.sv
src/code_bus.sv
src/codeword_matcher.sv
src/escape_sign_lane.sv
src/pair_assembler.sv
src/huff_pair_decoder.sv
bench/pair_checker.sv
bench/tb_huff_pair_decoder.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_huff_pair_decoder
FILELIST  = compile.f
LOG       = sim.log
BIN       = obj_dir/V$(TOP)
SOURCES   = $(wildcard src/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf obj_dir $(LOG)
